// File: files.f
+incdir+bench
src/mem_pkg.sv
src/dtlb.sv
src/access_check.sv
src/data_ram.sv
src/mem_unit.sv
bench/tb_mem_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build the memory stage testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -f files.f --top-module tb_mem_unit \
  --Mdir obj_dir -o sim_mem_unit || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_mem_unit > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "RESULT: no pass line in sim.log"; exit 1; }
echo "RESULT: PASS"

// File: bench/ref_model.svh
// Reference model of the memory stage for the testbench
// Shadow RAM, TLB contents, levels and the expected response of a command
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [dword_width_lp-1:0] shadow_mem [ram_words_lp];
logic                      ref_valid [tlb_els_lp];
logic [vtag_width_lp-1:0]  ref_vtag [tlb_els_lp];
logic [ptag_width_lp-1:0]  ref_ptag [tlb_els_lp];
// Permission bits as {u, w, d}
logic [2:0]                ref_perm [tlb_els_lp];
int                        ref_victim;
logic                      ref_trans_en;
priv_e                     ref_priv;
logic                      ref_sum;

function automatic int tlb_find(input logic [vtag_width_lp-1:0] vtag);
  int idx;
  idx = -1;
  for (int i = 0; i < tlb_els_lp; i++) begin
    if (ref_valid[i] && ref_vtag[i] == vtag) begin
      idx = i;
    end
  end
  return idx;
endfunction

function automatic void tlb_clear();
  for (int i = 0; i < tlb_els_lp; i++) begin
    ref_valid[i] = 1'b0;
  end
endfunction

// Same vtag refills in place, otherwise round robin
function automatic void tlb_insert(input logic [vtag_width_lp-1:0] vtag,
                                   input logic [ptag_width_lp-1:0] ptag,
                                   input logic [2:0] perm);
  int idx;
  idx = tlb_find(vtag);
  if (idx < 0) begin
    idx = ref_victim;
    ref_victim = (ref_victim + 1) % tlb_els_lp;
  end
  ref_valid[idx] = 1'b1;
  ref_vtag[idx]  = vtag;
  ref_ptag[idx]  = ptag;
  ref_perm[idx]  = perm;
endfunction

function automatic void reset_model();
  tlb_clear();
  ref_victim   = 0;
  ref_trans_en = 1'b0;
  ref_priv     = e_priv_m;
  ref_sum      = 1'b0;
endfunction

task automatic predict_cmd(input mem_op_e op, input logic [vaddr_width_lp-1:0] vaddr,
                           input logic [dword_width_lp-1:0] data, input logic poison,
                           output logic miss, output logic exc, output logic [3:0] cause,
                           output logic load_data_v,
                           output logic [dword_width_lp-1:0] load_data);
  logic                        store;
  logic                        word;
  logic                        pf;
  logic [paddr_width_lp-1:0]   paddr;
  logic [ram_idx_width_lp-1:0] ram_idx;
  logic [31:0]                 half;
  int                          idx;
  store = (op == e_sd) || (op == e_sw);
  word  = (op == e_lw) || (op == e_sw);
  idx   = tlb_find(vaddr[vaddr_width_lp-1:page_offset_width_lp]);
  paddr = vaddr;
  pf    = 1'b0;
  miss  = ref_trans_en && (idx < 0);
  if (ref_trans_en && idx >= 0) begin
    paddr = {ref_ptag[idx], vaddr[page_offset_width_lp-1:0]};
    pf = (ref_priv == e_priv_s && !ref_sum && ref_perm[idx][2])
       || (ref_priv == e_priv_u && !ref_perm[idx][2])
       || (store && !(ref_perm[idx][1] && ref_perm[idx][0]));
  end
  // RAM ends at 16 KiB
  exc   = !miss && (pf || paddr >= 20'h0_4000);
  cause = e_cause_none;
  if (exc) begin
    cause = pf ? (store ? e_store_page : e_load_page) : (store ? e_store_access : e_load_access);
  end
  ram_idx     = paddr[13:3];
  half        = paddr[2] ? shadow_mem[ram_idx][63:32] : shadow_mem[ram_idx][31:0];
  load_data_v = !miss && !exc && !store;
  load_data   = '0;
  if (!miss && !exc && !poison) begin
    if (store && !word) begin
      shadow_mem[ram_idx] = data;
    end else if (store && paddr[2]) begin
      shadow_mem[ram_idx][63:32] = data[31:0];
    end else if (store) begin
      shadow_mem[ram_idx][31:0] = data[31:0];
    end else if (word) begin
      load_data = {{32{half[31]}}, half};
    end else begin
      load_data = shadow_mem[ram_idx];
    end
  end
endtask

`endif

// File: bench/tb_mem_unit.sv
// Testbench for the data-side memory stage
// Table of commands with expected responses, checked two cycles after issue

module tb_mem_unit
  import mem_pkg::*;
 ();

  localparam logic [2:0] kind_idle   = 3'd0;
  localparam logic [2:0] kind_cmd    = 3'd1;
  localparam logic [2:0] kind_fill   = 3'd2;
  localparam logic [2:0] kind_flush  = 3'd3;
  localparam logic [2:0] kind_levels = 3'd4;

  typedef struct packed {
    logic [2:0]                kind;
    mem_op_e                   op;
    logic [vaddr_width_lp-1:0] vaddr;
    logic [dword_width_lp-1:0] data;
    logic                      poison;
    logic [vtag_width_lp-1:0]  vtag;
    logic [ptag_width_lp-1:0]  ptag;
    logic [2:0]                perm;
    logic                      trans_en;
    priv_e                     priv;
    logic                      sum;
    logic                      miss;
    logic                      exc;
    logic [3:0]                cause;
    logic                      load_data_v;
    logic [dword_width_lp-1:0] load_data;
  } row_t;

  typedef struct packed {
    logic [31:0]               due;
    logic                      miss;
    logic                      exc;
    logic [3:0]                cause;
    logic                      load_data_v;
    logic [dword_width_lp-1:0] load_data;
  } exp_t;

  logic                      clk_i;
  logic                      reset_i;
  logic                      cmd_v_i;
  mem_op_e                   cmd_op_i;
  logic [vaddr_width_lp-1:0] cmd_vaddr_i;
  logic [dword_width_lp-1:0] cmd_data_i;
  logic                      poison_i;
  logic                      fill_v_i;
  logic [vtag_width_lp-1:0]  fill_vtag_i;
  logic [ptag_width_lp-1:0]  fill_ptag_i;
  logic                      fill_u_i;
  logic                      fill_w_i;
  logic                      fill_d_i;
  logic                      flush_i;
  logic                      translation_en_i;
  priv_e                     priv_mode_i;
  logic                      sum_i;
  logic                      resp_v_o;
  logic [dword_width_lp-1:0] resp_data_o;
  logic                      resp_miss_o;
  logic                      resp_exc_o;
  cause_e                    resp_cause_o;

  row_t        rows [$];
  string       test_name [$];
  int          test_end [$];
  exp_t        exp_q [$];
  exp_t        cur_exp;
  logic [31:0] cyc = '0;
  logic [31:0] rng_state;
  logic        poison_pend;
  logic        checking;
  logic        table_ready;
  int          checks;
  int          errors;

  `include "ref_model.svh"

  mem_unit dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 32'd1;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [63:0] rand_dword();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  task automatic cmd_row(input mem_op_e op, input logic [vaddr_width_lp-1:0] vaddr,
                         input logic [dword_width_lp-1:0] data, input logic poison);
    row_t r;
    r        = '0;
    r.kind   = kind_cmd;
    r.op     = op;
    r.vaddr  = vaddr;
    r.data   = data;
    r.poison = poison;
    predict_cmd(op, vaddr, data, poison, r.miss, r.exc, r.cause, r.load_data_v, r.load_data);
    rows.push_back(r);
  endtask

  task automatic fill_row(input logic [vtag_width_lp-1:0] vtag,
                          input logic [ptag_width_lp-1:0] ptag, input logic [2:0] perm);
    row_t r;
    r      = '0;
    r.kind = kind_fill;
    r.vtag = vtag;
    r.ptag = ptag;
    r.perm = perm;
    tlb_insert(vtag, ptag, perm);
    rows.push_back(r);
  endtask

  task automatic flush_row();
    row_t r;
    r      = '0;
    r.kind = kind_flush;
    tlb_clear();
    rows.push_back(r);
  endtask

  // Idle first, so the previous command finishes stage 1 on the old levels
  task automatic level_row(input logic en, input priv_e priv, input logic sum);
    row_t r;
    r      = '0;
    r.kind = kind_idle;
    rows.push_back(r);
    r.kind       = kind_levels;
    r.trans_en   = en;
    r.priv       = priv;
    r.sum        = sum;
    ref_trans_en = en;
    ref_priv     = priv;
    ref_sum      = sum;
    rows.push_back(r);
  endtask

  task automatic close_test(input string name);
    test_name.push_back(name);
    test_end.push_back(rows.size());
  endtask

  task automatic build_table();
    logic [31:0]               r;
    mem_op_e                   op;
    logic [vaddr_width_lp-1:0] vaddr;
    cmd_row(e_sd, 20'h00100, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h00100, '0, 1'b0);
    cmd_row(e_sd, 20'h00108, rand_dword(), 1'b0);
    cmd_row(e_sw, 20'h00108, rand_dword() | 64'h8000_0000, 1'b0);
    cmd_row(e_sw, 20'h0010c, rand_dword() & ~64'h8000_0000, 1'b0);
    cmd_row(e_ld, 20'h00108, '0, 1'b0);
    cmd_row(e_lw, 20'h00108, '0, 1'b0);
    cmd_row(e_lw, 20'h0010c, '0, 1'b0);
    close_test("bare mode");
    level_row(1'b1, e_priv_s, 1'b0);
    cmd_row(e_ld, 20'h23010, '0, 1'b0);
    fill_row(8'h23, 8'h02, 3'b011);
    cmd_row(e_sd, 20'h23010, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h23010, '0, 1'b0);
    fill_row(8'h23, 8'h03, 3'b011);
    cmd_row(e_sd, 20'h23018, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h23018, '0, 1'b0);
    flush_row();
    cmd_row(e_ld, 20'h23010, '0, 1'b0);
    level_row(1'b0, e_priv_m, 1'b0);
    cmd_row(e_ld, 20'h02010, '0, 1'b0);
    cmd_row(e_ld, 20'h03018, '0, 1'b0);
    close_test("translation");
    // All four pages land on physical 0x1000
    level_row(1'b1, e_priv_s, 1'b0);
    fill_row(8'h31, 8'h01, 3'b111);
    fill_row(8'h32, 8'h01, 3'b001);
    fill_row(8'h33, 8'h01, 3'b010);
    fill_row(8'h34, 8'h01, 3'b011);
    cmd_row(e_sd, 20'h34200, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h31200, '0, 1'b0);
    cmd_row(e_sd, 20'h31200, rand_dword(), 1'b0);
    cmd_row(e_sd, 20'h32200, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h32200, '0, 1'b0);
    cmd_row(e_sd, 20'h33200, rand_dword(), 1'b0);
    level_row(1'b1, e_priv_u, 1'b0);
    cmd_row(e_ld, 20'h34200, '0, 1'b0);
    cmd_row(e_sd, 20'h34200, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h31200, '0, 1'b0);
    level_row(1'b1, e_priv_s, 1'b1);
    cmd_row(e_ld, 20'h31200, '0, 1'b0);
    level_row(1'b1, e_priv_s, 1'b0);
    cmd_row(e_ld, 20'h34200, '0, 1'b0);
    close_test("page faults");
    fill_row(8'h41, 8'h05, 3'b011);
    fill_row(8'h42, 8'h07, 3'b001);
    fill_row(8'h43, 8'h06, 3'b111);
    cmd_row(e_ld, 20'h41000, '0, 1'b0);
    cmd_row(e_sd, 20'h41008, rand_dword(), 1'b0);
    cmd_row(e_sd, 20'h42000, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h43000, '0, 1'b0);
    level_row(1'b0, e_priv_m, 1'b0);
    cmd_row(e_ld, 20'h04000, '0, 1'b0);
    cmd_row(e_sw, 20'h0fffc, rand_dword(), 1'b0);
    close_test("access faults");
    cmd_row(e_sd, 20'h00200, rand_dword(), 1'b0);
    cmd_row(e_ld, 20'h00200, '0, 1'b0);
    cmd_row(e_sd, 20'h00200, rand_dword(), 1'b1);
    cmd_row(e_ld, 20'h00200, '0, 1'b0);
    cmd_row(e_ld, 20'h00200, '0, 1'b1);
    cmd_row(e_lw, 20'h00204, '0, 1'b0);
    close_test("poison");
    for (int i = 0; i < 8; i++) begin
      cmd_row(e_sd, 20'h00300 + 20'(i * 8), rand_dword(), 1'b0);
    end
    // Random ops over the preloaded dwords, one in eight past the RAM
    for (int i = 0; i < 32; i++) begin
      r     = next_rand();
      op    = mem_op_e'(r[1:0]);
      vaddr = 20'h00300 + {14'd0, r[4:2], 3'b000};
      if (op == e_lw || op == e_sw) begin
        vaddr[2] = r[5];
      end
      if (r[8:6] == 3'd0) begin
        vaddr = vaddr + 20'h08000;
      end
      cmd_row(op, vaddr, rand_dword(), 1'b0);
    end
    close_test("back-to-back traffic");
  endtask

  task automatic apply_row(input row_t r);
    exp_t e;
    @(posedge clk_i);
    poison_i    <= poison_pend;
    poison_pend = (r.kind == kind_cmd) && r.poison;
    cmd_v_i     <= 1'b0;
    fill_v_i    <= 1'b0;
    flush_i     <= 1'b0;
    case (r.kind)
      kind_cmd: begin
        cmd_v_i     <= 1'b1;
        cmd_op_i    <= r.op;
        cmd_vaddr_i <= r.vaddr;
        cmd_data_i  <= r.data;
        if (!r.poison) begin
          e.due         = cyc + 32'd3;
          e.miss        = r.miss;
          e.exc         = r.exc;
          e.cause       = r.cause;
          e.load_data_v = r.load_data_v;
          e.load_data   = r.load_data;
          exp_q.push_back(e);
        end
      end
      kind_fill: begin
        fill_v_i    <= 1'b1;
        fill_vtag_i <= r.vtag;
        fill_ptag_i <= r.ptag;
        fill_u_i    <= r.perm[2];
        fill_w_i    <= r.perm[1];
        fill_d_i    <= r.perm[0];
      end
      kind_flush: flush_i <= 1'b1;
      kind_levels: begin
        translation_en_i <= r.trans_en;
        priv_mode_i      <= r.priv;
        sum_i            <= r.sum;
      end
      default: ;
    endcase
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) begin
      apply_row('0);
    end
    apply_row('0);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    assert (actual == expected)
    else begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (checking) begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        cur_exp = exp_q.pop_front();
        check_value("resp_v_o", 64'(resp_v_o), 64'd1);
        check_value("resp_miss_o", 64'(resp_miss_o), 64'(cur_exp.miss));
        check_value("resp_exc_o", 64'(resp_exc_o), 64'(cur_exp.exc));
        check_value("resp_cause_o", 64'(resp_cause_o), 64'(cur_exp.cause));
        if (cur_exp.load_data_v) begin
          check_value("resp_data_o", resp_data_o, cur_exp.load_data);
        end
      end else begin
        check_value("resp_v_o", 64'(resp_v_o), 64'd0);
      end
    end
  end

  initial begin
    wait (table_ready);
    #((rows.size() + 10) * 80);
    $display("Watchdog expired with %0d responses still outstanding", exp_q.size());
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int first;
    int n_cmds;
    int errs_before;
    reset_i          <= 1'b1;
    cmd_v_i          <= 1'b0;
    cmd_op_i         <= e_ld;
    cmd_vaddr_i      <= '0;
    cmd_data_i       <= '0;
    poison_i         <= 1'b0;
    fill_v_i         <= 1'b0;
    fill_vtag_i      <= '0;
    fill_ptag_i      <= '0;
    fill_u_i         <= 1'b0;
    fill_w_i         <= 1'b0;
    fill_d_i         <= 1'b0;
    flush_i          <= 1'b0;
    translation_en_i <= 1'b0;
    priv_mode_i      <= e_priv_m;
    sum_i            <= 1'b0;
    first       = 0;
    checks      = 0;
    errors      = 0;
    poison_pend = 1'b0;
    checking    = 1'b0;
    rng_state   = 32'h245f_b899;
    reset_model();
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i  <= 1'b0;
    checking = 1'b1;
    for (int t = 0; t < test_name.size(); t++) begin
      errs_before = errors;
      n_cmds      = 0;
      for (int i = first; i < test_end[t]; i++) begin
        apply_row(rows[i]);
        if (rows[i].kind == kind_cmd) begin
          n_cmds++;
        end
      end
      first = test_end[t];
      drain_responses();
      $display("test %0d (%s) done: %0d commands, %0d errors", t + 1, test_name[t], n_cmds,
               errors - errs_before);
    end
    $display("%0d tests, %0d checks, %0d errors", test_name.size(), checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: src/mem_unit.sv
// Data-side memory stage top level
// Data TLB, access checker and data RAM with a fixed two-cycle response

module mem_unit
  import mem_pkg::*;
 (input  logic                      clk_i
  , input  logic                      reset_i

  , input  logic                      cmd_v_i
  , input  mem_op_e                   cmd_op_i
  , input  logic [vaddr_width_lp-1:0] cmd_vaddr_i
  , input  logic [dword_width_lp-1:0] cmd_data_i

  , input  logic                      poison_i

  , input  logic                      fill_v_i
  , input  logic [vtag_width_lp-1:0]  fill_vtag_i
  , input  logic [ptag_width_lp-1:0]  fill_ptag_i
  , input  logic                      fill_u_i
  , input  logic                      fill_w_i
  , input  logic                      fill_d_i

  , input  logic                      flush_i

  , input  logic                      translation_en_i
  , input  priv_e                     priv_mode_i
  , input  logic                      sum_i

  , output logic                      resp_v_o
  , output logic [dword_width_lp-1:0] resp_data_o
  , output logic                      resp_miss_o
  , output logic                      resp_exc_o
  , output cause_e                    resp_cause_o
  );

  logic                        tlb_v, tlb_hit, tlb_u, tlb_w, tlb_d;
  logic [ptag_width_lp-1:0]    tlb_ptag;

  logic                        ram_rd_v, ram_wr_v, ram_word_sel, ram_word_op;
  logic [ram_idx_width_lp-1:0] ram_idx;
  logic [dword_width_lp-1:0]   ram_wdata;

  dtlb u_dtlb
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.lookup_v_i(cmd_v_i)
    ,.lookup_vtag_i(cmd_vaddr_i[vaddr_width_lp-1 -: vtag_width_lp])
    ,.fill_v_i(fill_v_i)
    ,.fill_vtag_i(fill_vtag_i)
    ,.fill_ptag_i(fill_ptag_i)
    ,.fill_u_i(fill_u_i)
    ,.fill_w_i(fill_w_i)
    ,.fill_d_i(fill_d_i)
    ,.flush_i(flush_i)
    ,.tlb_v_o(tlb_v)
    ,.tlb_hit_o(tlb_hit)
    ,.tlb_ptag_o(tlb_ptag)
    ,.tlb_u_o(tlb_u)
    ,.tlb_w_o(tlb_w)
    ,.tlb_d_o(tlb_d)
    );

  access_check u_check
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.cmd_v_i(cmd_v_i)
    ,.cmd_op_i(cmd_op_i)
    ,.cmd_vaddr_i(cmd_vaddr_i)
    ,.cmd_data_i(cmd_data_i)
    ,.poison_i(poison_i)
    ,.translation_en_i(translation_en_i)
    ,.priv_mode_i(priv_mode_i)
    ,.sum_i(sum_i)
    ,.tlb_v_i(tlb_v)
    ,.tlb_hit_i(tlb_hit)
    ,.tlb_ptag_i(tlb_ptag)
    ,.tlb_u_i(tlb_u)
    ,.tlb_w_i(tlb_w)
    ,.tlb_d_i(tlb_d)
    ,.ram_rd_v_o(ram_rd_v)
    ,.ram_wr_v_o(ram_wr_v)
    ,.ram_idx_o(ram_idx)
    ,.ram_word_sel_o(ram_word_sel)
    ,.ram_word_op_o(ram_word_op)
    ,.ram_wdata_o(ram_wdata)
    ,.resp_v_o(resp_v_o)
    ,.resp_miss_o(resp_miss_o)
    ,.resp_exc_o(resp_exc_o)
    ,.resp_cause_o(resp_cause_o)
    );

  // Read data lands in stage 2 next to the response flags
  data_ram u_ram
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.ram_rd_v_i(ram_rd_v)
    ,.ram_wr_v_i(ram_wr_v)
    ,.ram_idx_i(ram_idx)
    ,.ram_word_sel_i(ram_word_sel)
    ,.ram_word_op_i(ram_word_op)
    ,.ram_wdata_i(ram_wdata)
    ,.ram_rdata_o(resp_data_o)
    );

endmodule

// File: src/data_ram.sv
// Tightly coupled 64-bit data RAM
// Dword and word access, registered read with sign-extended word loads

module data_ram
  import mem_pkg::*;
 (input  logic                        clk_i
  , input  logic                        reset_i

  , input  logic                        ram_rd_v_i
  , input  logic                        ram_wr_v_i
  , input  logic [ram_idx_width_lp-1:0] ram_idx_i
  , input  logic                        ram_word_sel_i
  , input  logic                        ram_word_op_i
  , input  logic [dword_width_lp-1:0]   ram_wdata_i

  , output logic [dword_width_lp-1:0]   ram_rdata_o
  );

  logic [dword_width_lp-1:0] mem [ram_words_lp];

  logic [dword_width_lp-1:0] rd_dword;
  logic [word_width_lp-1:0]  rd_word;

  assign rd_dword = mem[ram_idx_i];
  assign rd_word  = ram_word_sel_i ? rd_dword[dword_width_lp-1:word_width_lp]
                                   : rd_dword[word_width_lp-1:0];

  // Word stores take the low half of the write data
  always_ff @(posedge clk_i) begin
    if (ram_wr_v_i) begin
      if (!ram_word_op_i) begin
        mem[ram_idx_i] <= ram_wdata_i;
      end else if (ram_word_sel_i) begin
        mem[ram_idx_i][dword_width_lp-1:word_width_lp] <= ram_wdata_i[word_width_lp-1:0];
      end else begin
        mem[ram_idx_i][word_width_lp-1:0] <= ram_wdata_i[word_width_lp-1:0];
      end
    end
  end

  // Holds the last read until the next one
  always_ff @(posedge clk_i) begin
    if (ram_rd_v_i) begin
      if (ram_word_op_i) begin
        ram_rdata_o <= {{word_width_lp{rd_word[word_width_lp-1]}}, rd_word};
      end else begin
        ram_rdata_o <= rd_dword;
      end
    end
  end

  // Single port, the checker never issues both
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(ram_rd_v_i && ram_wr_v_i))
    else $error("data_ram: read and write in the same cycle at idx %0d", ram_idx_i);

endmodule

// File: src/access_check.sv
// Stage-1 translation and permission checks for the memory stage
// Issues the data RAM strobes and registers the stage-2 response flags

module access_check
  import mem_pkg::*;
 (input  logic                        clk_i
  , input  logic                        reset_i

  , input  logic                        cmd_v_i
  , input  mem_op_e                     cmd_op_i
  , input  logic [vaddr_width_lp-1:0]   cmd_vaddr_i
  , input  logic [dword_width_lp-1:0]   cmd_data_i

  , input  logic                        poison_i

  , input  logic                        translation_en_i
  , input  priv_e                       priv_mode_i
  , input  logic                        sum_i

  , input  logic                        tlb_v_i
  , input  logic                        tlb_hit_i
  , input  logic [ptag_width_lp-1:0]    tlb_ptag_i
  , input  logic                        tlb_u_i
  , input  logic                        tlb_w_i
  , input  logic                        tlb_d_i

  , output logic                        ram_rd_v_o
  , output logic                        ram_wr_v_o
  , output logic [ram_idx_width_lp-1:0] ram_idx_o
  , output logic                        ram_word_sel_o
  , output logic                        ram_word_op_o
  , output logic [dword_width_lp-1:0]   ram_wdata_o

  , output logic                        resp_v_o
  , output logic                        resp_miss_o
  , output logic                        resp_exc_o
  , output cause_e                      resp_cause_o
  );

  mem_op_e                   op_r;
  logic [vaddr_width_lp-1:0] vaddr_r;
  logic [dword_width_lp-1:0] data_r;

  logic                      is_store;
  logic [ptag_width_lp-1:0]  ptag;
  logic [paddr_width_lp-1:0] paddr;
  logic                      tlb_miss, priv_fault, write_fault;
  logic                      page_fault, access_fault, exc;
  logic                      live, clean;
  cause_e                    cause;

  // Stage 1 command capture, valid travels with the TLB result
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      op_r    <= cmd_op_i;
      vaddr_r <= cmd_vaddr_i;
      data_r  <= cmd_data_i;
    end
  end

  assign is_store = (op_r == e_sd) | (op_r == e_sw);

  assign ptag  = translation_en_i ? tlb_ptag_i : vaddr_r[vaddr_width_lp-1 -: ptag_width_lp];
  assign paddr = {ptag, vaddr_r[page_offset_width_lp-1:0]};

  assign tlb_miss = translation_en_i & ~tlb_hit_i;

  assign priv_fault  = ((priv_mode_i == e_priv_s) & ~sum_i & tlb_u_i)
                     | ((priv_mode_i == e_priv_u) & ~tlb_u_i);
  assign write_fault = is_store & (~tlb_w_i | ~tlb_d_i);
  assign page_fault  = translation_en_i & tlb_hit_i & (priv_fault | write_fault);

  // Anything past the 16 KiB RAM
  assign access_fault = ~tlb_miss & (paddr[paddr_width_lp-1:ram_idx_width_lp+3] != '0);

  assign exc = page_fault | access_fault;

  // Page fault wins over access fault
  always_comb begin
    if (page_fault) begin
      cause = is_store ? e_store_page : e_load_page;
    end else if (access_fault) begin
      cause = is_store ? e_store_access : e_load_access;
    end else begin
      cause = e_cause_none;
    end
  end

  assign live  = tlb_v_i & ~poison_i;
  assign clean = live & ~tlb_miss & ~exc;

  assign ram_rd_v_o     = clean & ~is_store;
  assign ram_wr_v_o     = clean & is_store;
  assign ram_idx_o      = paddr[ram_idx_width_lp+2:3];
  assign ram_word_sel_o = paddr[2];
  assign ram_word_op_o  = (op_r == e_lw) | (op_r == e_sw);
  assign ram_wdata_o    = data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o    <= 1'b0;
      resp_miss_o <= 1'b0;
      resp_exc_o  <= 1'b0;
    end else begin
      resp_v_o    <= live;
      resp_miss_o <= live & tlb_miss;
      resp_exc_o  <= live & exc;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_cause_o <= cause;
  end

  // A poisoned command touches no RAM and leaves no response behind
  assert property (@(posedge clk_i) disable iff (reset_i)
    poison_i |-> !(ram_rd_v_o || ram_wr_v_o) ##1 !resp_v_o)
    else $error("access_check: poisoned command reached RAM or response");

endmodule

// File: src/dtlb.sv
// Fully associative data TLB
// Parallel vtag compare with a registered result, round-robin fill, flush

module dtlb
  import mem_pkg::*;
 (input  logic                     clk_i
  , input  logic                     reset_i

  , input  logic                     lookup_v_i
  , input  logic [vtag_width_lp-1:0] lookup_vtag_i

  , input  logic                     fill_v_i
  , input  logic [vtag_width_lp-1:0] fill_vtag_i
  , input  logic [ptag_width_lp-1:0] fill_ptag_i
  , input  logic                     fill_u_i
  , input  logic                     fill_w_i
  , input  logic                     fill_d_i

  , input  logic                     flush_i

  , output logic                     tlb_v_o
  , output logic                     tlb_hit_o
  , output logic [ptag_width_lp-1:0] tlb_ptag_o
  , output logic                     tlb_u_o
  , output logic                     tlb_w_o
  , output logic                     tlb_d_o
  );

  logic [tlb_els_lp-1:0]    valid_r;
  logic [vtag_width_lp-1:0] vtag_r [tlb_els_lp];
  logic [ptag_width_lp-1:0] ptag_r [tlb_els_lp];
  logic [tlb_els_lp-1:0]    u_r, w_r, d_r;

  logic [tlb_idx_width_lp-1:0] victim_r;

  logic [tlb_els_lp-1:0]       lookup_match, fill_match;
  logic [tlb_idx_width_lp-1:0] lookup_idx, fill_hit_idx, fill_idx;

  // Lookup and fill compare against the current contents
  always_comb begin
    lookup_idx   = '0;
    fill_hit_idx = '0;
    for (int i = 0; i < tlb_els_lp; i++) begin
      lookup_match[i] = valid_r[i] & (vtag_r[i] == lookup_vtag_i);
      fill_match[i]   = valid_r[i] & (vtag_r[i] == fill_vtag_i);
      if (lookup_match[i]) lookup_idx = tlb_idx_width_lp'(i);
      if (fill_match[i]) fill_hit_idx = tlb_idx_width_lp'(i);
    end
  end

  // Refill in place on a hit, else take the victim
  assign fill_idx = (|fill_match) ? fill_hit_idx : victim_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r   <= '0;
      victim_r  <= '0;
      tlb_v_o   <= 1'b0;
      tlb_hit_o <= 1'b0;
    end else begin
      if (flush_i) valid_r <= '0;
      if (fill_v_i) valid_r[fill_idx] <= 1'b1;
      if (fill_v_i & ~(|fill_match)) victim_r <= victim_r + 1'b1;
      tlb_v_o   <= lookup_v_i;
      tlb_hit_o <= lookup_v_i & (|lookup_match);
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      vtag_r[fill_idx] <= fill_vtag_i;
      ptag_r[fill_idx] <= fill_ptag_i;
      u_r[fill_idx]    <= fill_u_i;
      w_r[fill_idx]    <= fill_w_i;
      d_r[fill_idx]    <= fill_d_i;
    end
  end

  // Entry payload, only meaningful alongside tlb_hit_o
  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      tlb_ptag_o <= ptag_r[lookup_idx];
      tlb_u_o    <= u_r[lookup_idx];
      tlb_w_o    <= w_r[lookup_idx];
      tlb_d_o    <= d_r[lookup_idx];
    end
  end

  // Fill history must never leave two live entries with one vtag
  assert property (@(posedge clk_i) disable iff (reset_i)
    lookup_v_i |-> $onehot0(lookup_match))
    else $error("dtlb: multiple entries match vtag %h", lookup_vtag_i);

endmodule

// File: src/mem_pkg.sv
// Shared widths and encodings for the data-side memory stage
// Covers the command ops, privilege modes and exception causes

package mem_pkg;

  // Address geometry, 4 KiB pages
  localparam int vaddr_width_lp       = 20;
  localparam int paddr_width_lp       = 20;
  localparam int page_offset_width_lp = 12;
  localparam int vtag_width_lp        = vaddr_width_lp - page_offset_width_lp;
  localparam int ptag_width_lp        = paddr_width_lp - page_offset_width_lp;

  localparam int dword_width_lp = 64;
  localparam int word_width_lp  = dword_width_lp / 2;

  localparam int tlb_els_lp       = 8;
  localparam int tlb_idx_width_lp = $clog2(tlb_els_lp);

  // 16 KiB of physical memory
  localparam int ram_words_lp     = 2048;
  localparam int ram_idx_width_lp = $clog2(ram_words_lp);

  typedef enum logic [1:0] {
    e_ld = 2'b00,
    e_lw = 2'b01,
    e_sd = 2'b10,
    e_sw = 2'b11
  } mem_op_e;

  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } priv_e;

  // RISC-V mcause codes for data accesses
  typedef enum logic [3:0] {
    e_cause_none   = 4'd0,
    e_load_access  = 4'd5,
    e_store_access = 4'd7,
    e_load_page    = 4'd13,
    e_store_page   = 4'd15
  } cause_e;

endpackage
